/* hdl/ctrl_pkg.sv */
package ctrl_pkg;

	typedef enum logic [1:0] {
		KEY_OFF      = 2'd0,
		KEY_STRAIGHT = 2'd1,
		KEY_IAMBIC   = 2'd2
	} keyer_mode_e;

	typedef struct packed {
		logic [20:0] pad;     // reserved, written as zero.
		logic [7:0]  unit_ms; // dot length in ms, 0 acts as 1.
		logic        swap;    // exchange dot and dash paddles.
		keyer_mode_e mode;
	} keyer_cfg_t;

	typedef struct packed {
		logic [22:0] pad;        // reserved, written as zero.
		logic [7:0]  hang_ms;    // transmit hold after keyup.
		logic        ptt_enable; // ring acts as ptt in straight mode.
	} tx_cfg_t;

	// one command word, viewed by address
	typedef union packed {
		keyer_cfg_t keyer;
		tx_cfg_t    tx;
	} cmd_word_u;

	typedef struct packed {
		logic [4:0] rsvd_hi;
		logic       cw_key;    // debounced tip contact.
		logic       rsvd_lo;
		logic       ptt_state; // cw_on or external ptt.
	} resp_t;

	localparam logic [5:0] ADDR_KEYER = 6'h0F;
	localparam logic [5:0] ADDR_TX    = 6'h10;

	localparam keyer_cfg_t KEYER_CFG_RST = '{
		pad:     21'd0,
		unit_ms: 8'd10,
		swap:    1'b0,
		mode:    KEY_OFF
	};

	localparam tx_cfg_t TX_CFG_RST = '{
		pad:        23'd0,
		hang_ms:    8'd0,
		ptt_enable: 1'b0
	};

endpackage

/* hdl/tick_gen.sv */
module tick_gen #(
	parameter int QMS_DIV = 2500
) (
	input  logic clk,
	input  logic rst_n,
	output logic qmsec_pulse,
	output logic msec_pulse
);

	localparam int CNT_W = (QMS_DIV > 1) ? $clog2(QMS_DIV) : 1;
	localparam logic [CNT_W-1:0] RELOAD = CNT_W'(QMS_DIV - 1);

	logic [CNT_W-1:0] div_cnt;
	logic [1:0]       quarter_cnt;
	logic             div_zero;

	assign div_zero = (div_cnt == '0); // end of one quarter ms.

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			div_cnt     <= RELOAD;
			quarter_cnt <= 2'd0;
			qmsec_pulse <= 1'b0;
			msec_pulse  <= 1'b0;
		end else begin
			qmsec_pulse <= div_zero;
			msec_pulse  <= div_zero && (quarter_cnt == 2'd3); // every fourth quarter.
			if (div_zero) begin
				div_cnt     <= RELOAD;
				quarter_cnt <= quarter_cnt + 2'd1;
			end else begin
				div_cnt <= div_cnt - 1'b1;
			end
		end
	end

	// the ms strobe must always line up with a quarter strobe
	a_msec_on_qmsec: assert property (
		@(posedge clk) disable iff (!rst_n)
		msec_pulse |-> qmsec_pulse
	);

endmodule

/* hdl/debounce.sv */
module debounce #(
	parameter int DEB_MS = 3
) (
	input  logic clk,
	input  logic rst_n,
	input  logic msec_pulse,
	input  logic pb,
	output logic clean_pb
);

	localparam int CNT_W = $clog2(DEB_MS + 1);
	localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(DEB_MS);

	logic [1:0]       pb_sync; // contact is asynchronous to clk.
	logic             sample;
	logic [CNT_W-1:0] agree_cnt;
	logic [CNT_W-1:0] agree_next;

	always_ff @(posedge clk) begin
		pb_sync <= {pb_sync[0], pb};
	end

	// a changed sample restarts the run at one
	always_comb begin
		if (pb_sync[1] != sample)
			agree_next = CNT_W'(1);
		else if (agree_cnt != CNT_MAX)
			agree_next = agree_cnt + 1'b1;
		else
			agree_next = agree_cnt;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sample    <= 1'b0;
			agree_cnt <= '0;
			clean_pb  <= 1'b0; // key up.
		end else if (msec_pulse) begin
			sample    <= pb_sync[1];
			agree_cnt <= agree_next;
			if (agree_next == CNT_MAX)
				clean_pb <= pb_sync[1];
		end
	end

endmodule

/* hdl/cmd_regs.sv */
module cmd_regs import ctrl_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       cmd_rqst,
	input  logic [5:0] cmd_addr,
	input  cmd_word_u  cmd_data,
	output keyer_cfg_t keyer_cfg,
	output tx_cfg_t    tx_cfg
);

	logic wr_keyer;
	logic wr_tx;

	assign wr_keyer = cmd_rqst && (cmd_addr == ADDR_KEYER);
	assign wr_tx    = cmd_rqst && (cmd_addr == ADDR_TX);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			keyer_cfg <= KEYER_CFG_RST;
		end else if (wr_keyer) begin
			keyer_cfg <= cmd_data.keyer; // keyer view of the word.
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			tx_cfg <= TX_CFG_RST;
		end else if (wr_tx) begin
			tx_cfg <= cmd_data.tx; // transmit view of the word.
		end
	end

	// a strobed write needs a resolved address
	a_addr_known: assert property (
		@(posedge clk) disable iff (!rst_n)
		cmd_rqst |-> !$isunknown(cmd_addr)
	);

endmodule

/* hdl/iambic_keyer.sv */
module iambic_keyer import ctrl_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       msec_pulse,
	input  logic       dot_key,
	input  logic       dash_key,
	input  keyer_cfg_t keyer_cfg,
	output logic       cw_keydown
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_DOT,
		S_DASH,
		S_GAP
	} state_e;

	state_e     state;
	logic [9:0] elem_cnt;  // msec pulses left in element or gap.
	logic       last_dash; // element just sent was a dash.
	logic       alt_mem;   // opposite paddle seen during element.
	logic       dot_in;
	logic       dash_in;
	logic       alt_in;
	logic       same_in;
	logic [9:0] unit_len;
	logic [9:0] dash_len;
	logic       start_req;
	logic       start_dash;
	logic       cnt_done;

	assign dot_in  = keyer_cfg.swap ? dash_key : dot_key;
	assign dash_in = keyer_cfg.swap ? dot_key : dash_key;
	assign alt_in  = last_dash ? dot_in : dash_in;
	assign same_in = last_dash ? dash_in : dot_in;

	assign unit_len = (keyer_cfg.unit_ms == 8'd0) ? 10'd1 : {2'b00, keyer_cfg.unit_ms};
	assign dash_len = unit_len + {unit_len[8:0], 1'b0}; // three units.
	assign cnt_done = msec_pulse && (elem_cnt == 10'd1);

	// next element choice, from idle or at the end of a gap
	always_comb begin
		if (state == S_IDLE) begin
			start_req  = dot_in || dash_in;
			start_dash = !dot_in;
		end else begin
			start_req  = alt_mem || alt_in || same_in;
			start_dash = (alt_mem || alt_in) ? !last_dash : last_dash; // squeeze alternates.
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state      <= S_IDLE;
			elem_cnt   <= 10'd0;
			last_dash  <= 1'b0;
			alt_mem    <= 1'b0;
			cw_keydown <= 1'b0;
		end else if (keyer_cfg.mode != KEY_IAMBIC) begin
			state      <= S_IDLE;
			alt_mem    <= 1'b0;
			cw_keydown <= (keyer_cfg.mode == KEY_STRAIGHT) && dot_key; // tip only.
		end else begin
			case (state)
				S_IDLE: begin
					if (start_req) begin
						state      <= start_dash ? S_DASH : S_DOT;
						elem_cnt   <= start_dash ? dash_len : unit_len;
						last_dash  <= start_dash;
						cw_keydown <= 1'b1;
					end
				end
				S_DOT, S_DASH: begin
					alt_mem <= alt_mem || alt_in;
					if (cnt_done) begin
						state      <= S_GAP;
						elem_cnt   <= unit_len;
						cw_keydown <= 1'b0;
					end else if (msec_pulse) begin
						elem_cnt <= elem_cnt - 10'd1;
					end
				end
				S_GAP: begin
					alt_mem <= alt_mem || alt_in;
					if (cnt_done) begin
						alt_mem <= 1'b0;
						if (start_req) begin
							state      <= start_dash ? S_DASH : S_DOT;
							elem_cnt   <= start_dash ? dash_len : unit_len;
							last_dash  <= start_dash;
							cw_keydown <= 1'b1;
						end else begin
							state <= S_IDLE;
						end
					end else if (msec_pulse) begin
						elem_cnt <= elem_cnt - 10'd1;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// keyer silent once the off mode has been registered
	a_off_silent: assert property (
		@(posedge clk) disable iff (!rst_n)
		(keyer_cfg.mode == KEY_OFF) |=> !cw_keydown
	);

endmodule

/* hdl/tx_control.sv */
module tx_control import ctrl_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       run,
	input  logic       tx_on,
	input  logic       cw_on,
	input  logic       cw_keydown,
	input  logic       cw_key,
	input  logic       ring_key,
	input  logic       msec_pulse,
	input  keyer_cfg_t keyer_cfg,
	input  tx_cfg_t    tx_cfg,
	output logic       pa_exttr,
	output resp_t      resp
);

	logic       ext_ptt;
	logic       keydown_q;
	logic       keyup;
	logic [7:0] hang_cnt;
	logic       hang_active;
	logic       tx_req;
	resp_t      resp_next;

	assign ext_ptt = ring_key && tx_cfg.ptt_enable && (keyer_cfg.mode == KEY_STRAIGHT);
	assign keyup   = keydown_q && !cw_keydown;

	// covers the keyup cycle itself, before the timer is loaded
	assign hang_active = (hang_cnt != 8'd0) || (keyup && (tx_cfg.hang_ms != 8'd0));
	assign tx_req      = tx_on || ext_ptt || cw_keydown || hang_active;

	always_comb begin
		resp_next           = '0;
		resp_next.cw_key    = cw_key;
		resp_next.ptt_state = cw_on || ext_ptt;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			keydown_q <= 1'b0;
			hang_cnt  <= 8'd0;
		end else begin
			keydown_q <= cw_keydown;
			if (keyup)
				hang_cnt <= tx_cfg.hang_ms; // restart on every keyup.
			else if (msec_pulse && (hang_cnt != 8'd0))
				hang_cnt <= hang_cnt - 8'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pa_exttr <= 1'b0;
			resp     <= '0;
		end else begin
			pa_exttr <= run && tx_req;
			resp     <= resp_next;
		end
	end

	// the pa must drop one cycle after run goes away
	a_run_gates_pa: assert property (
		@(posedge clk) disable iff (!rst_n)
		!run |=> !pa_exttr
	);

endmodule

/* hdl/control.sv */
module control import ctrl_pkg::*; #(
	parameter int QMS_DIV = 2500,
	parameter int DEB_MS  = 3
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        run,
	input  logic        cmd_rqst,
	input  logic [5:0]  cmd_addr,
	input  logic [31:0] cmd_data,
	input  logic        tx_on,
	input  logic        cw_on,
	input  logic        io_phone_tip,  // active low.
	input  logic        io_phone_ring, // active low.
	output logic        cw_keydown,
	output logic        msec_pulse,
	output logic        qmsec_pulse,
	output logic        pa_exttr,
	output logic [7:0]  resp
);

	keyer_cfg_t keyer_cfg;
	tx_cfg_t    tx_cfg;
	logic       cw_key;
	logic       ring_key;

	tick_gen #(.QMS_DIV(QMS_DIV)) tick_gen0 (
		.clk         (clk),
		.rst_n       (rst_n),
		.qmsec_pulse (qmsec_pulse),
		.msec_pulse  (msec_pulse)
	);

	debounce #(.DEB_MS(DEB_MS)) de_phone_tip (
		.clk        (clk),
		.rst_n      (rst_n),
		.msec_pulse (msec_pulse),
		.pb         (~io_phone_tip),
		.clean_pb   (cw_key)
	);

	debounce #(.DEB_MS(DEB_MS)) de_phone_ring (
		.clk        (clk),
		.rst_n      (rst_n),
		.msec_pulse (msec_pulse),
		.pb         (~io_phone_ring),
		.clean_pb   (ring_key)
	);

	cmd_regs cmd_regs0 (
		.clk       (clk),
		.rst_n     (rst_n),
		.cmd_rqst  (cmd_rqst),
		.cmd_addr  (cmd_addr),
		.cmd_data  (cmd_data),
		.keyer_cfg (keyer_cfg),
		.tx_cfg    (tx_cfg)
	);

	iambic_keyer iambic_keyer0 (
		.clk        (clk),
		.rst_n      (rst_n),
		.msec_pulse (msec_pulse),
		.dot_key    (cw_key),   // tip is the dot paddle.
		.dash_key   (ring_key), // ring is the dash paddle.
		.keyer_cfg  (keyer_cfg),
		.cw_keydown (cw_keydown)
	);

	tx_control tx_control0 (
		.clk        (clk),
		.rst_n      (rst_n),
		.run        (run),
		.tx_on      (tx_on),
		.cw_on      (cw_on),
		.cw_keydown (cw_keydown),
		.cw_key     (cw_key),
		.ring_key   (ring_key),
		.msec_pulse (msec_pulse),
		.keyer_cfg  (keyer_cfg),
		.tx_cfg     (tx_cfg),
		.pa_exttr   (pa_exttr),
		.resp       (resp)
	);

endmodule

/* verif/control_tb.sv */
module control_tb import ctrl_pkg::*;;

	localparam int MS_CYC  = 32;  // clk cycles per ms with QMS_DIV of 8.
	localparam int TEST_MS = 10 + 80 + 10 + 260 + 300 + 100;
	localparam int LIMIT   = 2 * TEST_MS * MS_CYC;

	logic        clk;
	logic        rst_n;
	logic        run;
	logic        cmd_rqst;
	logic [5:0]  cmd_addr;
	logic [31:0] cmd_data;
	logic        tx_on;
	logic        cw_on;
	logic        io_phone_tip;
	logic        io_phone_ring;
	logic        cw_keydown;
	logic        msec_pulse;
	logic        qmsec_pulse;
	logic        pa_exttr;
	logic [7:0]  resp;

	string       test_name;
	logic [31:0] rng;
	int          cycles;
	logic        glitch_phase;

	// expected configuration, decoded from the writes the testbench issues
	logic [1:0]  m_mode;
	logic        m_swap;
	logic [7:0]  m_unit;
	logic        m_ptt;
	logic [7:0]  m_hang_ms;
	logic        m_kd_q;
	logic [7:0]  m_hang;
	logic        hang_on;
	logic        ext_exp;
	logic        pa_exp;
	logic        pa_known;

	// key contact ages in msec pulses since the last change
	logic        tip_q;
	logic        ring_q;
	int          tip_ms;
	int          ring_ms;
	int          tip_age;
	int          ring_age;

	// element run lengths for the iambic checks
	logic        kd_prev;
	int          on_ms;
	int          off_ms;
	int          last_on;
	int          unit_eff;
	logic        dot_h;
	logic        dash_h;
	logic        iam_ok;
	int          exp_on;

	control #(.QMS_DIV(8), .DEB_MS(3)) dut0 (
		.clk           (clk),
		.rst_n         (rst_n),
		.run           (run),
		.cmd_rqst      (cmd_rqst),
		.cmd_addr      (cmd_addr),
		.cmd_data      (cmd_data),
		.tx_on         (tx_on),
		.cw_on         (cw_on),
		.io_phone_tip  (io_phone_tip),
		.io_phone_ring (io_phone_ring),
		.cw_keydown    (cw_keydown),
		.msec_pulse    (msec_pulse),
		.qmsec_pulse   (qmsec_pulse),
		.pa_exttr      (pa_exttr),
		.resp          (resp)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// dot is one unit, dash three, a squeeze alternates from the last element
	function automatic int expected_on_ms(logic dot, logic dash, int unit, int last);
		if (dot && dash)
			return (last == unit) ? 3 * unit : unit;
		else if (dash)
			return 3 * unit;
		return unit;
	endfunction

	task automatic flag_mismatch(input string what, input int exp_val, input int act_val);
		$display("MISMATCH %s: %s expected %0d actual %0d", test_name, what, exp_val, act_val);
		$display("ERRORS FOUND");
		$fatal(1, "check failed");
	endtask

	task automatic wait_ms(input int n);
		repeat (n) begin
			@(posedge clk);
			while (!msec_pulse)
				@(posedge clk);
		end
		@(negedge clk);
	endtask

	task automatic write_cmd(input logic [5:0] addr, input logic [31:0] data);
		cmd_rqst = 1'b1;
		cmd_addr = addr;
		cmd_data = data;
		@(negedge clk);
		cmd_rqst = 1'b0;
		@(negedge clk);
	endtask

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			m_mode    <= 2'd0;
			m_swap    <= 1'b0;
			m_unit    <= 8'd10;
			m_ptt     <= 1'b0;
			m_hang_ms <= 8'd0;
		end else if (cmd_rqst) begin
			if (cmd_addr == ADDR_KEYER)
				{m_unit, m_swap, m_mode} <= cmd_data[10:0];
			if (cmd_addr == ADDR_TX)
				{m_hang_ms, m_ptt} <= cmd_data[8:0];
		end
	end

	assign hang_on = (m_hang != 8'd0) || (m_kd_q && !cw_keydown && (m_hang_ms != 8'd0));
	assign ext_exp = (m_mode == 2'd1) && m_ptt && !io_phone_ring;

	// hang time restarts on each keyup and counts msec pulses down
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			m_kd_q   <= 1'b0;
			m_hang   <= 8'd0;
			pa_exp   <= 1'b0;
			pa_known <= 1'b0;
		end else begin
			m_kd_q   <= cw_keydown;
			pa_exp   <= run && (tx_on || ext_exp || cw_keydown || hang_on);
			pa_known <= !((m_mode == 2'd1) && m_ptt) || (ring_age >= 5);
			if (m_kd_q && !cw_keydown)
				m_hang <= m_hang_ms;
			else if (msec_pulse && (m_hang != 8'd0))
				m_hang <= m_hang - 8'd1;
		end
	end

	assign tip_age  = (io_phone_tip == tip_q) ? tip_ms : 0;
	assign ring_age = (io_phone_ring == ring_q) ? ring_ms : 0;

	always_ff @(posedge clk) begin
		tip_q  <= io_phone_tip;
		ring_q <= io_phone_ring;
		if (!rst_n || (io_phone_tip != tip_q))
			tip_ms <= 0;
		else if (msec_pulse && (tip_ms < 255))
			tip_ms <= tip_ms + 1;
		if (!rst_n || (io_phone_ring != ring_q))
			ring_ms <= 0;
		else if (msec_pulse && (ring_ms < 255))
			ring_ms <= ring_ms + 1;
	end

	assign unit_eff = (m_unit == 8'd0) ? 1 : int'(m_unit);
	assign dot_h    = m_swap ? !io_phone_ring : !io_phone_tip;
	assign dash_h   = m_swap ? !io_phone_tip : !io_phone_ring;
	assign iam_ok   = (m_mode == 2'd2) && (tip_age >= 16) && (ring_age >= 16);
	assign exp_on   = expected_on_ms(dot_h, dash_h, unit_eff, last_on);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			kd_prev <= 1'b0;
			on_ms   <= 0;
			off_ms  <= 0;
			last_on <= 0;
		end else begin
			kd_prev <= cw_keydown;
			if (cw_keydown)
				on_ms <= (kd_prev ? on_ms : 0) + int'(msec_pulse);
			else
				off_ms <= (kd_prev ? 0 : off_ms) + int'(msec_pulse);
			if (kd_prev && !cw_keydown)
				last_on <= on_ms;
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= LIMIT) begin
			$display("timeout: run exceeded %0d cycles in test %s", LIMIT, test_name);
			$display("ERRORS FOUND");
			$fatal(1, "timeout");
		end
	end

	a_qmsec_period: assert property (@(posedge clk) disable iff (!rst_n)
		qmsec_pulse |=> (!qmsec_pulse)[*7] ##1 qmsec_pulse)
		else flag_mismatch("qmsec_pulse period", 1, qmsec_pulse);
	a_msec_period: assert property (@(posedge clk) disable iff (!rst_n)
		msec_pulse |=> (!msec_pulse)[*31] ##1 msec_pulse)
		else flag_mismatch("msec_pulse period", 1, msec_pulse);
	a_msec_alone: assert property (@(posedge clk) disable iff (!rst_n)
		msec_pulse |-> qmsec_pulse)
		else flag_mismatch("qmsec_pulse with msec_pulse", 1, qmsec_pulse);
	a_glitch: assert property (@(posedge clk) disable iff (!rst_n)
		glitch_phase |-> !resp[2])
		else flag_mismatch("resp bit 2 after glitch", 0, resp[2]);
	a_deb_delay: assert property (@(posedge clk) disable iff (!rst_n)
		$changed(resp[2]) |-> (tip_age >= 3) && (tip_age <= 4))
		else flag_mismatch("debounce msec pulses", 3, tip_age);
	a_deb_settled: assert property (@(posedge clk) disable iff (!rst_n)
		(tip_age == 5) |-> (resp[2] == !io_phone_tip))
		else flag_mismatch("settled resp bit 2", !io_phone_tip, resp[2]);
	// unused response bits always read as zero
	a_resp_rsvd: assert property (@(posedge clk) disable iff (!rst_n)
		(resp[7:3] == 5'd0) && !resp[1])
		else flag_mismatch("resp reserved bits", 0, {resp[7:3], resp[1]});
	// cw_keydown and resp register the debounced tip on the same edge
	a_straight: assert property (@(posedge clk) disable iff (!rst_n)
		($past(m_mode) == 2'd1) |-> (cw_keydown == resp[2]))
		else flag_mismatch("straight cw_keydown", resp[2], cw_keydown);
	a_key_off: assert property (@(posedge clk) disable iff (!rst_n)
		($past(m_mode) == 2'd0) |-> !cw_keydown)
		else flag_mismatch("cw_keydown in off mode", 0, cw_keydown);
	a_ptt_on: assert property (@(posedge clk) disable iff (!rst_n)
		$past((m_mode == 2'd1) && m_ptt && (ring_age >= 5) && !io_phone_ring) |-> resp[0])
		else flag_mismatch("resp bit 0 with ptt", 1, resp[0]);
	a_ptt_off: assert property (@(posedge clk) disable iff (!rst_n)
		$past(!((m_mode == 2'd1) && m_ptt) && !cw_on) |-> !resp[0])
		else flag_mismatch("resp bit 0 without ptt", 0, resp[0]);
	a_cw_on: assert property (@(posedge clk) disable iff (!rst_n)
		$past(cw_on) |-> resp[0])
		else flag_mismatch("resp bit 0 with cw_on", 1, resp[0]);
	a_elem_len: assert property (@(posedge clk) disable iff (!rst_n)
		(kd_prev && !cw_keydown && iam_ok && (dot_h || dash_h) && ($past(m_mode) == 2'd2))
		|-> (on_ms == exp_on))
		else flag_mismatch("element msec pulses", exp_on, on_ms);
	a_gap_len: assert property (@(posedge clk) disable iff (!rst_n)
		(!kd_prev && cw_keydown && iam_ok && (dot_h || dash_h) && ($past(m_mode) == 2'd2))
		|-> (off_ms == unit_eff))
		else flag_mismatch("gap msec pulses", unit_eff, off_ms);
	a_pa_follow: assert property (@(posedge clk) disable iff (!rst_n)
		pa_known |-> (pa_exttr == pa_exp))
		else flag_mismatch("pa_exttr", pa_exp, pa_exttr);
	a_run_drop: assert property (@(posedge clk) disable iff (!rst_n)
		!run |=> !pa_exttr)
		else flag_mismatch("pa_exttr after run low", 0, pa_exttr);

	initial begin
		int w;
		rst_n         = 1'b0;
		run           = 1'b0;
		cmd_rqst      = 1'b0;
		cmd_addr      = 6'd0;
		cmd_data      = 32'd0;
		tx_on         = 1'b0;
		cw_on         = 1'b0;
		io_phone_tip  = 1'b1;
		io_phone_ring = 1'b1;
		glitch_phase  = 1'b0;
		cycles        = 0;
		rng           = 32'd48;
		test_name     = "reset";
		repeat (8) @(negedge clk);
		rst_n = 1'b1;
		run   = 1'b1;

		test_name = "strobes";
		wait_ms(6);

		test_name = "debounce";
		repeat (8) begin
			rng = xorshift32(rng);
			w = 1 + int'(rng % 20); // shorter than one msec period.
			glitch_phase = 1'b1;
			io_phone_tip = 1'b0;
			repeat (w) @(negedge clk);
			io_phone_tip = 1'b1;
			wait_ms(6);
			glitch_phase = 1'b0;
		end
		io_phone_tip = 1'b0;
		wait_ms(8);
		io_phone_tip = 1'b1;
		wait_ms(8);

		test_name = "config";
		write_cmd(6'h05, 32'h0000_0012); // unused address, iambic data.
		io_phone_tip = 1'b0;
		wait_ms(6);
		io_phone_tip = 1'b1;
		wait_ms(6);
		write_cmd(ADDR_KEYER, 32'h0000_0011); // straight, unit 2.
		write_cmd(ADDR_TX, 32'h0000_0011);    // ptt on, hang 8.

		test_name = "straight";
		repeat (6) begin
			rng = xorshift32(rng);
			io_phone_tip = 1'b0;
			wait_ms(5 + int'(rng % 10));
			rng = xorshift32(rng);
			io_phone_tip = 1'b1;
			wait_ms(5 + int'(rng % 10));
		end
		io_phone_ring = 1'b0;
		wait_ms(10);
		io_phone_ring = 1'b1;
		wait_ms(10);
		write_cmd(ADDR_TX, 32'h0000_0010); // ptt off, hang 8.
		io_phone_ring = 1'b0;
		wait_ms(10);
		io_phone_ring = 1'b1;
		wait_ms(10);
		write_cmd(ADDR_KEYER, 32'h0000_0010); // off, unit 2.
		io_phone_tip = 1'b0;
		wait_ms(8);
		io_phone_tip = 1'b1;
		wait_ms(8);

		test_name = "iambic";
		write_cmd(ADDR_KEYER, 32'h0000_0012);
		io_phone_tip = 1'b0;
		wait_ms(40);
		io_phone_tip = 1'b1;
		wait_ms(20);
		io_phone_ring = 1'b0;
		wait_ms(40);
		io_phone_ring = 1'b1;
		wait_ms(20);
		io_phone_tip  = 1'b0;
		io_phone_ring = 1'b0;
		wait_ms(40);
		io_phone_tip  = 1'b1;
		io_phone_ring = 1'b1;
		wait_ms(20);
		write_cmd(ADDR_KEYER, 32'h0000_0016); // paddles swapped.
		io_phone_tip = 1'b0;
		wait_ms(40);
		io_phone_tip = 1'b1;
		wait_ms(20);
		io_phone_ring = 1'b0;
		wait_ms(40);
		io_phone_ring = 1'b1;
		wait_ms(20);

		test_name = "tx_control";
		write_cmd(ADDR_KEYER, 32'h0000_0011);
		write_cmd(ADDR_TX, 32'h0000_000A); // hang 5.
		tx_on = 1'b1;
		wait_ms(2);
		tx_on = 1'b0;
		repeat (3) begin
			io_phone_tip = 1'b0;
			wait_ms(6);
			io_phone_tip = 1'b1;
			wait_ms(12);
		end
		cw_on = 1'b1;
		wait_ms(2);
		cw_on = 1'b0;
		io_phone_tip = 1'b0;
		wait_ms(6);
		run = 1'b0;
		wait_ms(4);
		io_phone_tip = 1'b1;
		wait_ms(6);
		run = 1'b1;
		wait_ms(4);

		$display("NO ERRORS");
		$finish;
	end

endmodule

/* vlog.f */
hdl/ctrl_pkg.sv
hdl/tick_gen.sv
hdl/debounce.sv
hdl/cmd_regs.sv
hdl/iambic_keyer.sv
hdl/tx_control.sv
hdl/control.sv
verif/control_tb.sv
